// File: flist.f
+incdir+source
source/rvga_types.sv
source/inst_decoder.sv
source/imm_gen.sv
source/reg_file.sv
source/alu.sv
source/rvga_core.sv
tb/rvga_core_sva.sv
tb/rvga_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f flist.f --top-module rvga_core_tb -Mdir obj_dir \
  && ./obj_dir/Vrvga_core_tb | tee /dev/stderr | grep -qx "Done: no errors" \
  || { echo "Simulation failed" >&2; exit 1; }

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rvga_types::*; (
  input  rvga_word   a_i,
  input  rvga_word   b_i,
  input  rvga_word   rs1_i,
  input  rvga_word   rs2_i,
  input  rvga_funct3 funct3_i,
  input  rvga_funct7 funct7_i,
  input  logic       br_v_i,
  output rvga_word   result_o,
  output logic       br_taken_o
);

  logic signed [$bits(rvga_word)-1:0] a_s;
  logic [4:0] shamt;

  assign a_s   = a_i;
  assign shamt = b_i[4:0];

  always_comb begin
    result_o = a_i + b_i;
    // Plain add for address and target computation.
    if (!br_v_i) begin
      case (rvga_artop'(funct3_i))
        e_rvga_artop_addsub: result_o = funct7_i[5] ? (a_i - b_i) : (a_i + b_i);
        e_rvga_artop_sll:    result_o = a_i << shamt;
        e_rvga_artop_slt:    result_o = rvga_word'($signed(a_i) < $signed(b_i));
        e_rvga_artop_sltu:   result_o = rvga_word'(a_i < b_i);
        e_rvga_artop_xor:    result_o = a_i ^ b_i;
        e_rvga_artop_srx: begin
          if (funct7_i[5]) begin
            result_o = a_s >>> shamt;
          end else begin
            result_o = a_i >> shamt;
          end
        end
        e_rvga_artop_or:     result_o = a_i | b_i;
        default:             result_o = a_i & b_i;
      endcase
    end
  end

  // Branch condition from the register values.
  always_comb begin
    case (funct3_i)
      3'b000:  br_taken_o = (rs1_i == rs2_i);
      3'b001:  br_taken_o = (rs1_i != rs2_i);
      3'b100:  br_taken_o = ($signed(rs1_i) < $signed(rs2_i));
      3'b101:  br_taken_o = ($signed(rs1_i) >= $signed(rs2_i));
      3'b110:  br_taken_o = (rs1_i < rs2_i);
      3'b111:  br_taken_o = (rs1_i >= rs2_i);
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule : alu

`default_nettype wire

// File: source/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen import rvga_types::*; (
  input  rvga_word      ir_i,
  input  rvga_inst_type inst_type_i,
  output rvga_word      imm_o
);

  always_comb begin
    case (inst_type_i)
      e_rvga_inst_type_i: begin
        imm_o = {{20{ir_i[31]}}, ir_i[31:20]};
      end
      e_rvga_inst_type_s: begin
        imm_o = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
      end
      e_rvga_inst_type_b: begin
        imm_o = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
      end
      e_rvga_inst_type_u: begin
        imm_o = {ir_i[31:12], 12'b0};
      end
      e_rvga_inst_type_j: begin
        imm_o = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
      end
      // R type and unknown opcodes have no immediate.
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule : imm_gen

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import rvga_types::*; (
  input  rvga_word      pc_i,
  input  logic          ir_v_i,
  input  rvga_word      ir_i,
  output rvga_word      pc_o,
  output logic          v_o,
  output rvga_opcode    opcode_o,
  output rvga_inst_type inst_type_o,
  output rvga_reg_addr  rs1_o,
  output rvga_reg_addr  rs2_o,
  output rvga_reg_addr  rd_o,
  output rvga_funct3    funct3_o,
  output rvga_funct7    funct7_o,
  output logic          br_v_o,
  output logic          rd_w_v_o,
  output logic          imm_v_o,
  output logic          dmem_r_v_o,
  output logic          dmem_w_v_o,
  output logic          addpc_v_o,
  output logic          jmp_v_o,
  output logic          shift_v_o
);

  logic is_shift;

  // SLLI/SRxI keep funct7, it carries the arithmetic shift bit.
  assign is_shift = (ir_i[14:12] == e_rvga_artop_sll) || (ir_i[14:12] == e_rvga_artop_srx);

  always_comb begin
    pc_o        = pc_i;
    v_o         = ir_v_i;
    opcode_o    = rvga_opcode'(ir_i[6:0]);
    inst_type_o = e_rvga_inst_type_e;
    rs1_o       = ir_i[19:15];
    rs2_o       = ir_i[24:20];
    rd_o        = ir_i[11:7];
    funct3_o    = ir_i[14:12];
    funct7_o    = ir_i[31:25];
    br_v_o      = 1'b0;
    rd_w_v_o    = 1'b0;
    imm_v_o     = 1'b0;
    dmem_r_v_o  = 1'b0;
    dmem_w_v_o  = 1'b0;
    addpc_v_o   = 1'b0;
    jmp_v_o     = 1'b0;
    shift_v_o   = 1'b0;

    case (opcode_o)
      e_rvga_opcode_auipc: begin
        inst_type_o = e_rvga_inst_type_u;
        {imm_v_o, addpc_v_o, rd_w_v_o} = 3'b111;
      end
      e_rvga_opcode_lui: begin
        // Computed as x0 + imm.
        inst_type_o = e_rvga_inst_type_u;
        funct3_o    = e_rvga_artop_addsub;
        funct7_o    = '0;
        rs1_o       = '0;
        {imm_v_o, rd_w_v_o} = 2'b11;
      end
      e_rvga_opcode_jal: begin
        inst_type_o = e_rvga_inst_type_j;
        {addpc_v_o, imm_v_o, jmp_v_o, rd_w_v_o} = 4'b1111;
      end
      e_rvga_opcode_jalr: begin
        inst_type_o = e_rvga_inst_type_i;
        funct3_o    = e_rvga_artop_addsub;
        funct7_o    = '0;
        {imm_v_o, jmp_v_o, rd_w_v_o} = 3'b111;
      end
      e_rvga_opcode_imm: begin
        inst_type_o = e_rvga_inst_type_i;
        {imm_v_o, rd_w_v_o} = 2'b11;
        shift_v_o   = is_shift;
        if (!is_shift) begin
          funct7_o = '0;
        end
      end
      e_rvga_opcode_reg: begin
        inst_type_o = e_rvga_inst_type_r;
        rd_w_v_o    = 1'b1;
        shift_v_o   = is_shift;
      end
      e_rvga_opcode_br: begin
        inst_type_o = e_rvga_inst_type_b;
        {br_v_o, addpc_v_o, imm_v_o} = 3'b111;
      end
      e_rvga_opcode_ld: begin
        inst_type_o = e_rvga_inst_type_i;
        {imm_v_o, dmem_r_v_o, rd_w_v_o} = 3'b111;
      end
      e_rvga_opcode_st: begin
        inst_type_o = e_rvga_inst_type_s;
        {imm_v_o, dmem_w_v_o} = 2'b11;
      end
      default: begin
        inst_type_o = e_rvga_inst_type_e;
      end
    endcase
  end

endmodule : inst_decoder

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvga_defs.svh"

module reg_file import rvga_types::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  rvga_reg_addr rs1_i,
  input  rvga_reg_addr rs2_i,
  output rvga_word     rs1_data_o,
  output rvga_word     rs2_data_o,
  input  logic         we_i,
  input  rvga_reg_addr rd_i,
  input  rvga_word     rd_data_i
);

  rvga_word regs [`RVGA_NREGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `RVGA_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 reads as zero.
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule : reg_file

`default_nettype wire

// File: source/rvga_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvga_defs.svh"

module rvga_core import rvga_types::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         inst_req_i,
  input  rvga_word     inst_i,
  output logic         inst_ack_o,
  output rvga_word     pc_o,
  output logic         commit_v_o,
  output rvga_word     commit_pc_o,
  output logic         commit_illegal_o,
  output logic         commit_rd_we_o,
  output rvga_reg_addr commit_rd_o,
  output rvga_word     commit_data_o
);

  localparam int DMEM_AW = $clog2(`RVGA_DMEM_WORDS);

  rvga_hs_state  state_q;
  rvga_word      pc_q;
  rvga_word      ir_q;
  rvga_word      dmem [`RVGA_DMEM_WORDS];

  rvga_word      dec_pc;
  logic          dec_v;
  rvga_opcode    dec_opcode;
  rvga_inst_type dec_inst_type;
  rvga_reg_addr  dec_rs1, dec_rs2, dec_rd;
  rvga_funct3    dec_funct3;
  rvga_funct7    dec_funct7;
  logic          dec_br_v, dec_rd_w_v, dec_imm_v, dec_dmem_r_v, dec_dmem_w_v;
  logic          dec_addpc_v, dec_jmp_v, dec_shift_v;

  rvga_word      imm;
  rvga_word      rs1_data, rs2_data;
  rvga_word      op_a, op_b, alu_b, alu_result;
  logic          alu_add_only, br_taken;
  logic          illegal, rf_we, dmem_we;
  rvga_word      pc_plus4, next_pc, load_data, wb_data;
  logic [DMEM_AW-1:0] dmem_addr;

  inst_decoder i_decoder (
    .pc_i        (pc_q),
    .ir_v_i      (state_q == e_rvga_hs_state_exec),
    .ir_i        (ir_q),
    .pc_o        (dec_pc),
    .v_o         (dec_v),
    .opcode_o    (dec_opcode),
    .inst_type_o (dec_inst_type),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .rd_o        (dec_rd),
    .funct3_o    (dec_funct3),
    .funct7_o    (dec_funct7),
    .br_v_o      (dec_br_v),
    .rd_w_v_o    (dec_rd_w_v),
    .imm_v_o     (dec_imm_v),
    .dmem_r_v_o  (dec_dmem_r_v),
    .dmem_w_v_o  (dec_dmem_w_v),
    .addpc_v_o   (dec_addpc_v),
    .jmp_v_o     (dec_jmp_v),
    .shift_v_o   (dec_shift_v)
  );

  imm_gen i_imm_gen (
    .ir_i        (ir_q),
    .inst_type_i (dec_inst_type),
    .imm_o       (imm)
  );

  reg_file i_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (dec_rs1),
    .rs2_i      (dec_rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (dec_rd),
    .rd_data_i  (wb_data)
  );

  assign op_a  = dec_addpc_v ? dec_pc : rs1_data;
  assign op_b  = dec_imm_v ? imm : rs2_data;
  assign alu_b = dec_shift_v ? {27'b0, op_b[4:0]} : op_b;

  // AUIPC, JAL, branches and memory ops carry immediate bits in funct3.
  assign alu_add_only = dec_br_v | dec_addpc_v | dec_dmem_r_v | dec_dmem_w_v;

  alu i_alu (
    .a_i        (op_a),
    .b_i        (alu_b),
    .rs1_i      (rs1_data),
    .rs2_i      (rs2_data),
    .funct3_i   (dec_funct3),
    .funct7_i   (dec_funct7),
    .br_v_i     (alu_add_only),
    .result_o   (alu_result),
    .br_taken_o (br_taken)
  );

  assign illegal = (dec_inst_type == e_rvga_inst_type_e) ||
                   ((dec_dmem_r_v || dec_dmem_w_v) && (dec_funct3 != 3'b010));
  assign rf_we   = dec_v & dec_rd_w_v & ~illegal;
  assign dmem_we = dec_v & dec_dmem_w_v & ~illegal;

  assign dmem_addr = alu_result[DMEM_AW+1:2];
  assign load_data = dmem[dmem_addr];
  assign pc_plus4  = dec_pc + 32'd4;

  // Load data first, then the link address, then the ALU.
  assign wb_data = dec_dmem_r_v ? load_data : (dec_jmp_v ? pc_plus4 : alu_result);

  always_comb begin
    next_pc = pc_plus4;
    if (dec_jmp_v && (dec_opcode == e_rvga_opcode_jalr)) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (dec_jmp_v || (dec_br_v && br_taken)) begin
      next_pc = alu_result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dmem_we) begin
      dmem[dmem_addr] <= rs2_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q          <= e_rvga_hs_state_idle;
      pc_q             <= '0;
      inst_ack_o       <= 1'b0;
      commit_v_o       <= 1'b0;
      commit_illegal_o <= 1'b0;
      commit_rd_we_o   <= 1'b0;
    end else begin
      commit_v_o <= 1'b0;
      case (state_q)
        e_rvga_hs_state_idle: begin
          if (inst_req_i) begin
            ir_q    <= inst_i;
            state_q <= e_rvga_hs_state_exec;
          end
        end
        e_rvga_hs_state_exec: begin
          pc_q             <= next_pc;
          commit_v_o       <= dec_v;
          commit_pc_o      <= dec_pc;
          commit_illegal_o <= illegal;
          commit_rd_we_o   <= rf_we;
          commit_rd_o      <= dec_rd;
          commit_data_o    <= dec_dmem_w_v ? rs2_data : wb_data;
          inst_ack_o       <= 1'b1;
          state_q          <= e_rvga_hs_state_ack;
        end
        default: begin
          // Hold ack until the requester lets go of req.
          if (!inst_req_i) begin
            inst_ack_o <= 1'b0;
            state_q    <= e_rvga_hs_state_idle;
          end
        end
      endcase
    end
  end

  assign pc_o = pc_q;

endmodule : rvga_core

`default_nettype wire

// File: source/rvga_defs.svh
`ifndef RVGA_DEFS_SVH
`define RVGA_DEFS_SVH

// Core-wide sizes for the rvga RV32I core.

// Data path width in bits.
`define RVGA_XLEN 32

// Architectural integer registers.
`define RVGA_NREGS 32

// Words of data memory inside the core top.
// Word addressed, so it must stay a power of two.
`define RVGA_DMEM_WORDS 16

`endif

// File: source/rvga_types.sv
`default_nettype none

`include "rvga_defs.svh"

package rvga_types;

  typedef logic [`RVGA_XLEN-1:0] rvga_word;
  typedef logic [$clog2(`RVGA_NREGS)-1:0] rvga_reg_addr;
  typedef logic [2:0] rvga_funct3;
  typedef logic [6:0] rvga_funct7;

  // Major opcodes, bits 6:0 of the instruction.
  typedef enum logic [6:0] {
    e_rvga_opcode_auipc = 7'b0010111,
    e_rvga_opcode_lui   = 7'b0110111,
    e_rvga_opcode_jal   = 7'b1101111,
    e_rvga_opcode_jalr  = 7'b1100111,
    e_rvga_opcode_imm   = 7'b0010011,
    e_rvga_opcode_reg   = 7'b0110011,
    e_rvga_opcode_br    = 7'b1100011,
    e_rvga_opcode_ld    = 7'b0000011,
    e_rvga_opcode_st    = 7'b0100011
  } rvga_opcode;

  // Instruction formats, e marks an unknown opcode.
  typedef enum logic [2:0] {
    e_rvga_inst_type_r,
    e_rvga_inst_type_i,
    e_rvga_inst_type_s,
    e_rvga_inst_type_b,
    e_rvga_inst_type_u,
    e_rvga_inst_type_j,
    e_rvga_inst_type_e
  } rvga_inst_type;

  // Arithmetic funct3 codes of OP and OP-IMM.
  typedef enum logic [2:0] {
    e_rvga_artop_addsub = 3'b000,
    e_rvga_artop_sll    = 3'b001,
    e_rvga_artop_slt    = 3'b010,
    e_rvga_artop_sltu   = 3'b011,
    e_rvga_artop_xor    = 3'b100,
    e_rvga_artop_srx    = 3'b101,
    e_rvga_artop_or     = 3'b110,
    e_rvga_artop_and    = 3'b111
  } rvga_artop;

  typedef enum logic [1:0] {
    e_rvga_hs_state_idle,
    e_rvga_hs_state_exec,
    e_rvga_hs_state_ack
  } rvga_hs_state;

endpackage : rvga_types

`default_nettype wire

// File: tb/rvga_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module rvga_core_sva (
  input logic clk_i,
  input logic reset_i,
  input logic inst_req_i,
  input logic inst_ack_o,
  input logic commit_v_o,
  input logic commit_illegal_o,
  input logic commit_rd_we_o
);

  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(inst_ack_o) |-> $past(inst_req_i))
    else $error("inst_ack_o rose without a pending inst_req_i");

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(inst_ack_o) |-> !$past(inst_req_i))
    else $error("inst_ack_o fell while inst_req_i was still high");

  commit_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o |=> !commit_v_o)
    else $error("commit_v_o stayed high for two cycles");

  // A req rising into an idle core retires two cycles later, and nothing else does.
  commit_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o == ($past(inst_req_i, 2) && !$past(inst_req_i, 3) && !$past(inst_ack_o, 2)))
    else $error("commit_v_o not two cycles after an accepted request");

  illegal_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_v_o |-> !(commit_illegal_o && commit_rd_we_o))
    else $error("illegal commit with a register write");

endmodule : rvga_core_sva

bind rvga_core rvga_core_sva i_sva (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .inst_req_i       (inst_req_i),
  .inst_ack_o       (inst_ack_o),
  .commit_v_o       (commit_v_o),
  .commit_illegal_o (commit_illegal_o),
  .commit_rd_we_o   (commit_rd_we_o)
);

`default_nettype wire

// File: tb/rvga_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rvga_core_tb;

  localparam int CLK_NS       = 10;
  localparam int RESET_CYCLES = 5;
  localparam int PROG_WORDS   = 64;
  // One transfer takes three cycles, twelve leaves room.
  localparam int WATCHDOG_NS  = (PROG_WORDS * 12 + RESET_CYCLES + 2) * CLK_NS;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        inst_req_i;
  logic [31:0] inst_i;
  logic        inst_ack_o;
  logic [31:0] pc_o;
  logic        commit_v_o;
  logic [31:0] commit_pc_o;
  logic        commit_illegal_o;
  logic        commit_rd_we_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;

  logic [31:0] prog [PROG_WORDS];
  logic [31:0] mregs [32];
  logic [31:0] exp_pc [PROG_WORDS];
  logic [31:0] exp_data [PROG_WORDS];
  logic [4:0]  exp_rd [PROG_WORDS];
  logic        exp_we [PROG_WORDS];
  logic        exp_chk [PROG_WORDS];
  logic        exp_ill [PROG_WORDS];
  int          n_exp  = 0;
  int          n_seen = 0;
  int          errors = 0;
  logic [31:0] seed   = 32'h5013ce44;

  rvga_core i_dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .inst_req_i       (inst_req_i),
    .inst_i           (inst_i),
    .inst_ack_o       (inst_ack_o),
    .pc_o             (pc_o),
    .commit_v_o       (commit_v_o),
    .commit_pc_o      (commit_pc_o),
    .commit_illegal_o (commit_illegal_o),
    .commit_rd_we_o   (commit_rd_we_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o)
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_next();
    seed = xorshift32(seed);
    return seed;
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] shift_result(input logic [31:0] a, input logic [4:0] sh,
                                               input logic left, input logic arith);
    if (left) begin
      return a << sh;
    end else if (arith) begin
      return $signed(a) >>> sh;
    end
    return a >> sh;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Appends one expected commit and retires its register write in the model.
  task automatic record(input logic [31:0] pc, input logic we, input logic [4:0] rd,
                        input logic [31:0] data, input logic chk, input logic ill);
    exp_pc[n_exp]   = pc;
    exp_we[n_exp]   = we;
    exp_rd[n_exp]   = rd;
    exp_data[n_exp] = data;
    exp_chk[n_exp]  = chk;
    exp_ill[n_exp]  = ill;
    n_exp++;
    if (we && (rd != 5'd0)) begin
      mregs[rd] = data;
    end
  endtask

  task automatic build_program();
    logic [31:0] pc, r, a, b, v, imm, step;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [3:0]  w;
    int          k;
    // Slots skipped by jumps hold harmless ADDI x0 words tagged with the index.
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = 32'h13 | (32'(i) << 20);
    end
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    pc = '0;
    k  = 0;
    while (pc < 32'd240) begin
      r    = rand_next();
      rd   = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
      rs1  = r[9:5];
      rs2  = r[14:10];
      imm  = {{20{r[31]}}, r[31:20]};
      a    = mregs[rs1];
      b    = mregs[rs2];
      v    = pc + 32'd4;
      step = 32'd4;
      case (k % 14)
        0: begin
          prog[pc[7:2]] = itype_word(imm[11:0], rs1, 3'd0, rd, 7'h13);
          record(pc, 1'b1, rd, a + imm, 1'b1, 1'b0);
        end
        1: begin
          prog[pc[7:2]] = itype_word(imm[11:0], rs1, 3'd2, rd, 7'h13);
          record(pc, 1'b1, rd, ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0, 1'b1, 1'b0);
        end
        2: begin
          prog[pc[7:2]] = itype_word(imm[11:0], rs1, 3'd4, rd, 7'h13);
          record(pc, 1'b1, rd, a ^ imm, 1'b1, 1'b0);
        end
        3: begin
          f3 = r[15] ? 3'd5 : 3'd1;
          f7 = (r[15] && r[16]) ? 7'h20 : 7'h00;
          prog[pc[7:2]] = itype_word({f7, r[24:20]}, rs1, f3, rd, 7'h13);
          record(pc, 1'b1, rd, shift_result(a, r[24:20], !r[15], f7[5]), 1'b1, 1'b0);
        end
        4: begin
          f7 = r[15] ? 7'h20 : 7'h00;
          prog[pc[7:2]] = rtype_word(f7, rs2, rs1, 3'd0, rd, 7'h33);
          record(pc, 1'b1, rd, r[15] ? (a - b) : (a + b), 1'b1, 1'b0);
        end
        5: begin
          f3 = r[15] ? 3'd5 : 3'd1;
          f7 = r[15] ? 7'h20 : 7'h00;
          prog[pc[7:2]] = rtype_word(f7, rs2, rs1, f3, rd, 7'h33);
          record(pc, 1'b1, rd, shift_result(a, b[4:0], !r[15], r[15]), 1'b1, 1'b0);
        end
        6: begin
          prog[pc[7:2]] = utype_word(r[31:12], rd, 7'h37);
          record(pc, 1'b1, rd, {r[31:12], 12'h000}, 1'b1, 1'b0);
        end
        7: begin
          prog[pc[7:2]] = utype_word(r[31:12], rd, 7'h17);
          record(pc, 1'b1, rd, pc + {r[31:12], 12'h000}, 1'b1, 1'b0);
        end
        8: begin
          // Codes 2 and 3 are no branch, so fold them onto BLT and BLTU.
          f3 = r[17:15];
          if ((f3 == 3'd2) || (f3 == 3'd3)) begin
            f3 = {1'b1, f3[0], 1'b0};
          end
          if (r[18]) begin
            rs2 = rs1;
            b   = a;
          end
          prog[pc[7:2]] = btype_word(13'd8, rs2, rs1, f3);
          record(pc, 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
          step = branch_taken(f3, a, b) ? 32'd8 : 32'd4;
        end
        9: begin
          prog[pc[7:2]] = jtype_word(21'd8, rd);
          record(pc, 1'b1, rd, pc + 32'd4, 1'b1, 1'b0);
          step = 32'd8;
        end
        10: begin
          // AUIPC gives JALR a known base, the jump skips one slot.
          prog[pc[7:2]] = utype_word(20'd0, rd, 7'h17);
          record(pc, 1'b1, rd, pc, 1'b1, 1'b0);
          prog[v[7:2]] = itype_word(12'd12, rd, 3'd0, rs2, 7'h67);
          record(v, 1'b1, rs2, v + 32'd4, 1'b1, 1'b0);
          step = 32'd12;
        end
        11: begin
          w = r[19:16];
          prog[pc[7:2]] = stype_word({6'd0, w, 2'b00}, rs2, 5'd0, 3'd2);
          record(pc, 1'b0, 5'd0, b, 1'b1, 1'b0);
          prog[v[7:2]] = itype_word({6'd0, w, 2'b00}, 5'd0, 3'd2, rd, 7'h03);
          record(v, 1'b1, rd, b, 1'b1, 1'b0);
          step = 32'd8;
        end
        12: begin
          if (r[15]) begin
            prog[pc[7:2]] = {r[31:7], 7'b0001011};
          end else begin
            prog[pc[7:2]] = itype_word(imm[11:0], rs1, 3'd0, rd, 7'h03);
          end
          record(pc, 1'b0, rd, 32'd0, 1'b0, 1'b1);
        end
        default: begin
          prog[pc[7:2]] = itype_word(imm[11:0], rs1, 3'd0, 5'd0, 7'h13);
          record(pc, 1'b1, 5'd0, a + imm, 1'b1, 1'b0);
          prog[v[7:2]] = rtype_word(7'h00, 5'd0, 5'd0, 3'd0, rd, 7'h33);
          record(v, 1'b1, rd, 32'd0, 1'b1, 1'b0);
          step = 32'd8;
        end
      endcase
      pc = pc + step;
      k++;
    end
  endtask

  // One four-phase transfer of the word at pc_o.
  task automatic transfer(input int idx);
    assert (pc_o == exp_pc[idx]) else begin
      errors++;
      $display("ERR pc_o got %h expected %h", pc_o, exp_pc[idx]);
    end
    inst_i     = prog[pc_o[7:2]];
    inst_req_i = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!inst_ack_o);
    inst_req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (inst_ack_o);
  endtask

  always @(negedge clk_i) begin
    if (!reset_i && commit_v_o) begin
      if (n_seen >= n_exp) begin
        errors++;
        $display("A commit arrived after the last expected instruction");
      end else begin
        assert (commit_pc_o == exp_pc[n_seen]) else begin
          errors++;
          $display("ERR commit_pc_o got %h expected %h", commit_pc_o, exp_pc[n_seen]);
        end
        assert (commit_illegal_o == exp_ill[n_seen]) else begin
          errors++;
          $display("ERR commit_illegal_o got %h expected %h", commit_illegal_o,
                   exp_ill[n_seen]);
        end
        assert (commit_rd_we_o == exp_we[n_seen]) else begin
          errors++;
          $display("ERR commit_rd_we_o got %h expected %h", commit_rd_we_o, exp_we[n_seen]);
        end
        assert (!exp_we[n_seen] || (commit_rd_o == exp_rd[n_seen])) else begin
          errors++;
          $display("ERR commit_rd_o got %h expected %h", commit_rd_o, exp_rd[n_seen]);
        end
        assert (!exp_chk[n_seen] || (commit_data_o == exp_data[n_seen])) else begin
          errors++;
          $display("ERR commit_data_o got %h expected %h", commit_data_o,
                   exp_data[n_seen]);
        end
      end
      n_seen++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the core did not finish the program in time");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    reset_i    = 1'b1;
    inst_req_i = 1'b0;
    inst_i     = '0;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int n = 0; n < n_exp; n++) begin
      transfer(n);
    end
    @(posedge clk_i);
    if (n_seen != n_exp) begin
      errors++;
      $display("Saw %0d commits for %0d instructions sent", n_seen, n_exp);
    end
    $display("Commits checked %0d, errors %0d", n_seen, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : rvga_core_tb

`default_nettype wire
